/* logic/noc_pkg.sv */
package noc_pkg;

    ////////////////////
    // flit format
    ////////////////////

    localparam int flit_width    = 40;
    localparam int coord_width   = 2;                               // one of dest_x / dest_y
    localparam int payload_width = flit_width - 2 * coord_width;    // 36 bits of data

    // flit layout, msb first
    //   [39:38] dest_x
    //   [37:36] dest_y
    //   [35:0]  payload

    ////////////////////
    // router ports
    ////////////////////

    // route decision and arbiter index
    typedef enum logic [2:0] {
        dir_local = 3'd0,
        dir_east  = 3'd1,
        dir_west  = 3'd2,
        dir_north = 3'd3,    // increasing y
        dir_south = 3'd4
    } port_dir_e;

endpackage

/* logic/flit_injector.sv */
`timescale 1ns/1ns

module flit_injector #(
    parameter int count_width = 8
) (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              in_valid,
    input  logic [noc_pkg::coord_width-1:0]   in_dest_x,
    input  logic [noc_pkg::coord_width-1:0]   in_dest_y,
    input  logic [noc_pkg::payload_width-1:0] in_payload,
    output logic                              inj_valid,
    output logic [noc_pkg::flit_width-1:0]    inj_flit,
    output logic [count_width-1:0]            injected_count
);
    import noc_pkg::*;

    logic [flit_width-1:0] packed_flit;

    assign packed_flit = {in_dest_x, in_dest_y, in_payload};    // dest_x on top

    ////////////////////
    // injection stage
    ////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            inj_valid      <= 1'b0;
            injected_count <= '0;
        end else begin
            inj_valid <= in_valid;
            if (in_valid) begin
                injected_count <= injected_count + 1'b1;    // wraps at 2^count_width
            end
        end
    end

    // flit word loaded on each accepted injection
    always_ff @(posedge clk) begin
        if (in_valid) begin
            inj_flit <= packed_flit;
        end
    end

endmodule

/* logic/mesh_router.sv */
`timescale 1ns/1ns

module mesh_router #(
    parameter int mesh_cols = 4,
    parameter int mesh_rows = 4,
    parameter int node_x    = 0,
    parameter int node_y    = 0
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           in_valid_e,
    input  logic                           in_valid_w,
    input  logic                           in_valid_n,
    input  logic                           in_valid_s,
    input  logic                           in_valid_local,
    input  logic [noc_pkg::flit_width-1:0] in_flit_e,
    input  logic [noc_pkg::flit_width-1:0] in_flit_w,
    input  logic [noc_pkg::flit_width-1:0] in_flit_n,
    input  logic [noc_pkg::flit_width-1:0] in_flit_s,
    input  logic [noc_pkg::flit_width-1:0] in_flit_local,
    output logic                           out_valid_e,
    output logic                           out_valid_w,
    output logic                           out_valid_n,
    output logic                           out_valid_s,
    output logic                           out_valid_local,
    output logic [noc_pkg::flit_width-1:0] out_flit_e,
    output logic [noc_pkg::flit_width-1:0] out_flit_w,
    output logic [noc_pkg::flit_width-1:0] out_flit_n,
    output logic [noc_pkg::flit_width-1:0] out_flit_s,
    output logic [noc_pkg::flit_width-1:0] out_flit_local
);
    import noc_pkg::*;

    localparam int port_count = 5;
    localparam logic [coord_width-1:0] my_x = coord_width'(node_x);
    localparam logic [coord_width-1:0] my_y = coord_width'(node_y);

    // output ports that have a neighbour, bit order as port_dir_e
    localparam logic [port_count-1:0] port_exists = {
        node_y > 0,                 // south
        node_y < mesh_rows - 1,     // north
        node_x > 0,                 // west
        node_x < mesh_cols - 1,     // east
        1'b1                        // local
    };

    // requests in priority order: local, west, east, south, north
    logic [port_count-1:0] req_v;
    logic [flit_width-1:0] req_f   [port_count];
    port_dir_e             req_dir [port_count];

    logic [port_count-1:0] grant_v;
    logic [flit_width-1:0] grant_f [port_count];

    logic [port_count-1:0] out_v_q;
    logic [flit_width-1:0] out_f_q [port_count];

    ////////////////////
    // XY route compute
    ////////////////////

    function automatic port_dir_e route(input logic [flit_width-1:0] flit);
        logic [coord_width-1:0] dest_x;
        logic [coord_width-1:0] dest_y;
        port_dir_e              dir;
        dest_x = flit[flit_width-1 -: coord_width];
        dest_y = flit[flit_width-coord_width-1 -: coord_width];
        if (dest_x > my_x)
            dir = dir_east;                         // x resolved first
        else if (dest_x < my_x)
            dir = dir_west;
        else if (dest_y > my_y)
            dir = dir_north;
        else if (dest_y < my_y)
            dir = dir_south;
        else
            dir = dir_local;                        // arrived
        return dir;
    endfunction

    assign req_v    = {in_valid_n, in_valid_s, in_valid_e, in_valid_w, in_valid_local};
    assign req_f[0] = in_flit_local;
    assign req_f[1] = in_flit_w;
    assign req_f[2] = in_flit_e;
    assign req_f[3] = in_flit_s;
    assign req_f[4] = in_flit_n;

    always_comb begin
        for (int i = 0; i < port_count; i++) begin
            req_dir[i] = route(req_f[i]);
        end
    end

    ////////////////////
    // output arbiters
    ////////////////////

    // fixed priority, lowest request index wins, so scan from the top down
    always_comb begin
        for (int o = 0; o < port_count; o++) begin
            grant_v[o] = 1'b0;
            grant_f[o] = '0;
            for (int i = port_count - 1; i >= 0; i--) begin
                if (req_v[i] && req_dir[i] == port_dir_e'(o)) begin
                    grant_v[o] = 1'b1;
                    grant_f[o] = req_f[i];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_v_q <= '0;
        end else begin
            out_v_q <= grant_v & port_exists;   // nothing leaves toward a mesh edge
        end
    end

    always_ff @(posedge clk) begin
        for (int o = 0; o < port_count; o++) begin
            out_f_q[o] <= grant_f[o];
        end
    end

    assign out_valid_local = out_v_q[dir_local];
    assign out_valid_e     = out_v_q[dir_east];
    assign out_valid_w     = out_v_q[dir_west];
    assign out_valid_n     = out_v_q[dir_north];
    assign out_valid_s     = out_v_q[dir_south];
    assign out_flit_local  = out_f_q[dir_local];
    assign out_flit_e      = out_f_q[dir_east];
    assign out_flit_w      = out_f_q[dir_west];
    assign out_flit_n      = out_f_q[dir_north];
    assign out_flit_s      = out_f_q[dir_south];

endmodule

/* logic/delivery_log.sv */
`timescale 1ns/1ns

module delivery_log #(
    parameter int mesh_cols   = 4,
    parameter int mesh_rows   = 4,
    parameter int count_width = 8
) (
    input  logic                                                    clk,
    input  logic                                                    reset,
    input  logic [mesh_cols*mesh_rows-1:0]                          local_valid,
    input  logic [mesh_cols*mesh_rows-1:0][noc_pkg::flit_width-1:0] local_flit,
    input  logic                                                    rd_req,
    input  logic [$clog2(mesh_cols*mesh_rows)-1:0]                  rd_node,
    output logic                                                    rd_valid,
    output logic [count_width-1:0]                                  rd_count,
    output logic [noc_pkg::payload_width-1:0]                       rd_checksum
);
    import noc_pkg::*;

    localparam int node_count = mesh_cols * mesh_rows;

    logic [count_width-1:0]   count_q    [node_count];
    logic [payload_width-1:0] checksum_q [node_count];

    ////////////////////
    // per-node log
    ////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int n = 0; n < node_count; n++) begin
                count_q[n]    <= '0;
                checksum_q[n] <= '0;
            end
        end else begin
            for (int n = 0; n < node_count; n++) begin
                if (local_valid[n]) begin
                    count_q[n]    <= count_q[n] + 1'b1;     // wraps
                    checksum_q[n] <= checksum_q[n] ^ local_flit[n][payload_width-1:0];
                end
            end
        end
    end

    ////////////////////
    // read port
    ////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_req;                     // one cycle after the request
        end
    end

    // values as they stood before this edge's update
    always_ff @(posedge clk) begin
        if (rd_req) begin
            if (int'(rd_node) < node_count) begin
                rd_count    <= count_q[rd_node];
                rd_checksum <= checksum_q[rd_node];
            end else begin
                rd_count    <= '0;                  // no such node
                rd_checksum <= '0;
            end
        end
    end

endmodule

/* logic/mesh_top.sv */
`timescale 1ns/1ns

module mesh_top #(
    parameter int mesh_cols   = 4,
    parameter int mesh_rows   = 4,
    parameter int count_width = 8
) (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   in_valid,
    input  logic [noc_pkg::coord_width-1:0]        in_dest_x,
    input  logic [noc_pkg::coord_width-1:0]        in_dest_y,
    input  logic [noc_pkg::payload_width-1:0]      in_payload,
    output logic [count_width-1:0]                 injected_count,
    input  logic                                   rd_req,
    input  logic [$clog2(mesh_cols*mesh_rows)-1:0] rd_node,
    output logic                                   rd_valid,
    output logic [count_width-1:0]                 rd_count,
    output logic [noc_pkg::payload_width-1:0]      rd_checksum
);
    import noc_pkg::*;

    localparam int node_count = mesh_cols * mesh_rows;

    logic                  inj_valid;
    logic [flit_width-1:0] inj_flit;

    // router outputs, indexed by node_y*mesh_cols+node_x
    logic [node_count-1:0]                 v_e, v_w, v_n, v_s;
    logic [node_count-1:0][flit_width-1:0] f_e, f_w, f_n, f_s;
    logic [node_count-1:0]                 local_valid;
    logic [node_count-1:0][flit_width-1:0] local_flit;

    flit_injector #(.count_width(count_width)) u_injector (
        .clk(clk), .reset(reset),
        .in_valid(in_valid), .in_dest_x(in_dest_x), .in_dest_y(in_dest_y),
        .in_payload(in_payload),
        .inj_valid(inj_valid), .inj_flit(inj_flit), .injected_count(injected_count)
    );

    ////////////////////
    // router grid
    ////////////////////

    for (genvar y = 0; y < mesh_rows; y++) begin : g_row
        for (genvar x = 0; x < mesh_cols; x++) begin : g_col
            localparam int  idx   = y * mesh_cols + x;
            localparam bit  has_e = x < mesh_cols - 1;
            localparam bit  has_w = x > 0;
            localparam bit  has_n = y < mesh_rows - 1;
            localparam bit  has_s = y > 0;
            localparam int  e_idx = has_e ? idx + 1 : idx;      // self when on the edge
            localparam int  w_idx = has_w ? idx - 1 : idx;
            localparam int  n_idx = has_n ? idx + mesh_cols : idx;
            localparam int  s_idx = has_s ? idx - mesh_cols : idx;

            mesh_router #(
                .mesh_cols(mesh_cols), .mesh_rows(mesh_rows), .node_x(x), .node_y(y)
            ) u_router (
                .clk(clk), .reset(reset),
                .in_valid_e(has_e ? v_w[e_idx] : 1'b0),   .in_flit_e(has_e ? f_w[e_idx] : '0),
                .in_valid_w(has_w ? v_e[w_idx] : 1'b0),   .in_flit_w(has_w ? f_e[w_idx] : '0),
                .in_valid_n(has_n ? v_s[n_idx] : 1'b0),   .in_flit_n(has_n ? f_s[n_idx] : '0),
                .in_valid_s(has_s ? v_n[s_idx] : 1'b0),   .in_flit_s(has_s ? f_n[s_idx] : '0),
                .in_valid_local(idx == 0 ? inj_valid : 1'b0),  // injection at (0,0) only
                .in_flit_local(idx == 0 ? inj_flit : '0),
                .out_valid_e(v_e[idx]), .out_flit_e(f_e[idx]),
                .out_valid_w(v_w[idx]), .out_flit_w(f_w[idx]),
                .out_valid_n(v_n[idx]), .out_flit_n(f_n[idx]),
                .out_valid_s(v_s[idx]), .out_flit_s(f_s[idx]),
                .out_valid_local(local_valid[idx]), .out_flit_local(local_flit[idx])
            );
        end
    end

    delivery_log #(
        .mesh_cols(mesh_cols), .mesh_rows(mesh_rows), .count_width(count_width)
    ) u_log (
        .clk(clk), .reset(reset),
        .local_valid(local_valid), .local_flit(local_flit),
        .rd_req(rd_req), .rd_node(rd_node),
        .rd_valid(rd_valid), .rd_count(rd_count), .rd_checksum(rd_checksum)
    );

endmodule

/* tests/mesh_assertions.sv */
`timescale 1ns/1ns

module mesh_assertions #(
    parameter int node_x = 0,
    parameter int node_y = 0
) (
    input logic                           clk,
    input logic                           reset,
    input logic                           in_valid_e, in_valid_w, in_valid_n, in_valid_s,
    input logic [noc_pkg::flit_width-1:0] in_flit_e, in_flit_w, in_flit_n, in_flit_s,
    input logic                           out_valid_e, out_valid_w, out_valid_n, out_valid_s,
    input logic                           out_valid_local,
    input logic [noc_pkg::flit_width-1:0] out_flit_e, out_flit_w, out_flit_n, out_flit_s,
    input logic [noc_pkg::flit_width-1:0] out_flit_local
);
    import noc_pkg::*;

    logic [coord_width-1:0] local_dest_x;
    logic [coord_width-1:0] local_dest_y;

    assign local_dest_x = out_flit_local[flit_width-1 -: coord_width];
    assign local_dest_y = out_flit_local[flit_width-coord_width-1 -: coord_width];

    ////////////////////
    // delivery address
    ////////////////////

    a_local_dest: assert property (@(posedge clk) disable iff (reset)
        out_valid_local |-> (local_dest_x == coord_width'(node_x) &&
                             local_dest_y == coord_width'(node_y)))
        else $error("router (%0d,%0d) delivered a flit for another node", node_x, node_y);

    ////////////////////
    // no u-turns
    ////////////////////

    // one register stage, so the same flit would show one edge later
    a_uturn_e: assert property (@(posedge clk) disable iff (reset)
        in_valid_e |=> !(out_valid_e && out_flit_e == $past(in_flit_e)))
        else $error("router (%0d,%0d) sent a flit back east", node_x, node_y);
    a_uturn_w: assert property (@(posedge clk) disable iff (reset)
        in_valid_w |=> !(out_valid_w && out_flit_w == $past(in_flit_w)))
        else $error("router (%0d,%0d) sent a flit back west", node_x, node_y);
    a_uturn_n: assert property (@(posedge clk) disable iff (reset)
        in_valid_n |=> !(out_valid_n && out_flit_n == $past(in_flit_n)))
        else $error("router (%0d,%0d) sent a flit back north", node_x, node_y);
    a_uturn_s: assert property (@(posedge clk) disable iff (reset)
        in_valid_s |=> !(out_valid_s && out_flit_s == $past(in_flit_s)))
        else $error("router (%0d,%0d) sent a flit back south", node_x, node_y);

endmodule

bind mesh_router mesh_assertions #(.node_x(node_x), .node_y(node_y)) u_assertions (
    .clk(clk), .reset(reset),
    .in_valid_e(in_valid_e), .in_valid_w(in_valid_w),
    .in_valid_n(in_valid_n), .in_valid_s(in_valid_s),
    .in_flit_e(in_flit_e), .in_flit_w(in_flit_w), .in_flit_n(in_flit_n), .in_flit_s(in_flit_s),
    .out_valid_e(out_valid_e), .out_valid_w(out_valid_w),
    .out_valid_n(out_valid_n), .out_valid_s(out_valid_s), .out_valid_local(out_valid_local),
    .out_flit_e(out_flit_e), .out_flit_w(out_flit_w),
    .out_flit_n(out_flit_n), .out_flit_s(out_flit_s), .out_flit_local(out_flit_local)
);

/* tests/mesh_tb.sv */
`timescale 1ns/1ns

module mesh_tb;
    import noc_pkg::*;

    localparam int mesh_cols    = 4;
    localparam int mesh_rows    = 4;
    localparam int node_count   = mesh_cols * mesh_rows;
    localparam int drain_cycles = mesh_cols + mesh_rows + 4;
    localparam int burst_len    = 64;

    logic                     clk;
    logic                     reset;
    logic                     in_valid;
    logic [coord_width-1:0]   in_dest_x;
    logic [coord_width-1:0]   in_dest_y;
    logic [payload_width-1:0] in_payload;
    logic [7:0]               injected_count;
    logic                     rd_req;
    logic [3:0]               rd_node;
    logic                     rd_valid;
    logic [7:0]               rd_count;
    logic [payload_width-1:0] rd_checksum;

    // lines of the data file
    int                       inj_test [$];
    logic [1:0]               inj_x    [$];
    logic [1:0]               inj_y    [$];
    logic [35:0]              inj_p    [$];
    int                       exp_test [$];
    int                       exp_node [$];
    logic [7:0]               exp_count[$];
    logic [35:0]              exp_chk  [$];
    int                       file_tests;

    // reference model, one flit lands only at its destination
    logic [7:0]               model_count [node_count];
    logic [35:0]              model_chk   [node_count];
    int                       model_injected;
    logic [7:0]               got_count   [node_count];
    logic [35:0]              got_chk     [node_count];

    logic [15:0]              lfsr_state;
    logic                     load_ok;
    int                       errors      = 0;
    int                       checks      = 0;
    int                       test_errors = 0;
    int                       tests_run   = 0;
    int                       cycle_count = 0;
    int                       cycle_limit = 0;

    mesh_top dut (
        .clk(clk), .reset(reset),
        .in_valid(in_valid), .in_dest_x(in_dest_x), .in_dest_y(in_dest_y),
        .in_payload(in_payload), .injected_count(injected_count),
        .rd_req(rd_req), .rd_node(rd_node),
        .rd_valid(rd_valid), .rd_count(rd_count), .rd_checksum(rd_checksum)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout, the run did not finish within %0d cycles", cycle_limit);
            $display("Test failures found");
            $finish;
        end
    end

    ////////////////////
    // data file
    ////////////////////

    task automatic load_cases(output logic ok);
        int               fd;
        int               r;
        int               cur_test;
        logic [7:0]       kind;
        logic [35:0]      f1, f2, f3, f4;
        logic [8*120-1:0] line;
        cur_test   = 0;
        file_tests = 0;
        fd = $fopen("tests/mesh_cases.txt", "r");
        ok = (fd != 0);
        if (ok) begin
            while (!$feof(fd)) begin
                line = '0;
                r = $fgets(line, fd);
                r = $sscanf(line, " %c %h %h %h %h", kind, f1, f2, f3, f4);
                if (r == 5 && kind == "i") begin
                    if (int'(f1) != cur_test) file_tests++;     // new test starts
                    cur_test = int'(f1);
                    inj_test.push_back(cur_test);
                    inj_x.push_back(f2[1:0]);
                    inj_y.push_back(f3[1:0]);
                    inj_p.push_back(f4);
                end else if (r == 4 && kind == "e") begin
                    exp_test.push_back(cur_test);               // belongs to the last test
                    exp_node.push_back(int'(f1));
                    exp_count.push_back(f2[7:0]);
                    exp_chk.push_back(f3);
                end
            end
            $fclose(fd);
            cycle_limit = 10 + inj_test.size() + burst_len
                        + (file_tests + 2) * (node_count * 2 + drain_cycles) + 200;
        end
    endtask

    ////////////////////
    // stimulus helpers
    ////////////////////

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};    // x^16+x^14+x^13+x^11+1
    endfunction

    task automatic draw_bits(input int n, output logic [35:0] val);
        val = '0;
        for (int b = 0; b < n; b++) begin
            lfsr_state = lfsr_step(lfsr_state);
            val = {val[34:0], lfsr_state[0]};
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        reset = 1'b1;
        repeat (10) @(negedge clk);
        reset = 1'b0;
        for (int n = 0; n < node_count; n++) begin
            model_count[n] = '0;
            model_chk[n]   = '0;
        end
        model_injected = 0;
    endtask

    // called on a falling edge, returns on the next one
    task automatic send_flit(input logic [1:0] x, input logic [1:0] y, input logic [35:0] p);
        int node;
        node       = int'(y) * mesh_cols + int'(x);
        in_valid   = 1'b1;
        in_dest_x  = x;
        in_dest_y  = y;
        in_payload = p;
        model_count[node] = model_count[node] + 8'd1;
        model_chk[node]   = model_chk[node] ^ p;
        model_injected++;
        @(negedge clk);
    endtask

    ////////////////////
    // result checks
    ////////////////////

    task automatic compare_value(input string name, input logic [35:0] got,
                                 input logic [35:0] exp);
        checks++;
        if (got !== exp) begin
            $display("Fail %s: got %h expected %h", name, got, exp);
            test_errors++;
        end
    endtask

    task automatic read_all_nodes();
        for (int n = 0; n < node_count; n++) begin
            rd_req  = 1'b1;
            rd_node = 4'(n);
            @(negedge clk);
            rd_req = 1'b0;
            checks++;
            if (rd_valid !== 1'b1) begin
                $display("node %0d read: rd_valid did not rise one cycle after rd_req", n);
                test_errors++;
            end
            got_count[n] = rd_count;
            got_chk[n]   = rd_checksum;
            @(negedge clk);
            if (rd_valid !== 1'b0) begin
                $display("node %0d read: rd_valid stayed high for more than one cycle", n);
                test_errors++;
            end
        end
    endtask

    task automatic finish_test(input int num);
        int node;
        repeat (drain_cycles) @(negedge clk);
        read_all_nodes();
        for (int n = 0; n < node_count; n++) begin
            compare_value($sformatf("rd_count[%0d]", n), 36'(got_count[n]), 36'(model_count[n]));
            compare_value($sformatf("rd_checksum[%0d]", n), got_chk[n], model_chk[n]);
        end
        for (int k = 0; k < exp_test.size(); k++) begin
            if (exp_test[k] == num) begin
                node = exp_node[k];
                compare_value($sformatf("rd_count[%0d]", node), 36'(got_count[node]),
                              36'(exp_count[k]));
                compare_value($sformatf("rd_checksum[%0d]", node), got_chk[node], exp_chk[k]);
            end
        end
        compare_value("injected_count", 36'(injected_count), 36'(model_injected[7:0]));
        $display("test %0d finished with %0d errors", num, test_errors);
        errors += test_errors;
        test_errors = 0;
        tests_run++;
    endtask

    task automatic run_tests();
        int          i;
        int          t;
        logic [35:0] x;
        logic [35:0] y;
        logic [35:0] p;
        apply_reset();
        finish_test(1);                                 // empty log after reset
        i = 0;
        t = 1;
        while (i < inj_test.size()) begin
            t = inj_test[i];
            apply_reset();
            while (i < inj_test.size() && inj_test[i] == t) begin
                send_flit(inj_x[i], inj_y[i], inj_p[i]);    // back to back
                i++;
            end
            in_valid = 1'b0;
            finish_test(t);
        end
        apply_reset();
        lfsr_state = 16'd91;
        for (int k = 0; k < burst_len; k++) begin
            draw_bits(2, x);
            draw_bits(2, y);
            draw_bits(36, p);
            send_flit(x[1:0], y[1:0], p);
        end
        in_valid = 1'b0;
        finish_test(t + 1);
    endtask

    initial begin
        reset      = 1'b1;
        in_valid   = 1'b0;
        in_dest_x  = '0;
        in_dest_y  = '0;
        in_payload = '0;
        rd_req     = 1'b0;
        rd_node    = '0;
        load_cases(load_ok);
        if (!load_ok) begin
            $display("cannot open the data file tests/mesh_cases.txt");
            $display("Test failures found");
        end else begin
            run_tests();
            $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
            if (errors == 0) begin
                $display("All tests passed!");
            end else begin
                $display("Test failures found");
            end
        end
        $finish;
    end

endmodule

/* sources.f */
logic/noc_pkg.sv
logic/flit_injector.sv
logic/mesh_router.sv
logic/delivery_log.sv
logic/mesh_top.sv
tests/mesh_assertions.sv
tests/mesh_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the mesh testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module mesh_tb -f sources.f \
    > build.log 2>&1 || { echo "verilator build failed, see build.log"; exit 1; }
./obj_dir/Vmesh_tb > sim.log 2>&1 || echo "simulation exited with an error" >> sim.log
cat sim.log
! grep -q "Test failures found" sim.log && grep -q "All tests passed!" sim.log \
    && echo "PASS" || { echo "FAIL"; exit 1; }

/* tests/mesh_cases.txt */
# i <test> <dest_x> <dest_y> <payload>  one flit, the lines of a test go out back to back
# e <node> <count> <checksum>           log after the preceding test, node = y*4+x, all hex
i 2 0 0 123456789
i 2 3 3 fedcba987
e 0 1 123456789
e f 1 fedcba987
i 3 0 0 c00000000
i 3 1 0 c00000010
i 3 2 0 c00000020
i 3 3 0 c00000030
i 3 0 1 c00000001
i 3 1 1 c00000011
i 3 2 1 c00000021
i 3 3 1 c00000031
i 3 0 2 c00000002
i 3 1 2 c00000012
i 3 2 2 c00000022
i 3 3 2 c00000032
i 3 0 3 c00000003
i 3 1 3 c00000013
i 3 2 3 c00000023
i 3 3 3 c00000033
e 0 1 c00000000
e 3 1 c00000030
e 5 1 c00000011
e a 1 c00000022
e c 1 c00000003
e f 1 c00000033
i 4 1 2 0aaaaaaaa
i 4 3 0 055555555
i 4 1 2 0f0f0f0f0
i 4 0 3 123123123
i 4 1 2 100000001
e 9 3 15a5a5a5b
e 3 1 055555555
e c 1 123123123
